// File: hdl/control_matrix.sv
`default_nettype none

module control_matrix #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                     clk_i,
    input  wire                     resetComplete,
    input  wire  [DATA_WIDTH-1:0]   ir_i,
    input  wire                     mem_busy_i,
    output logic                    ready_o,
    output logic                    ir_ld_o,
    output logic                    pc_ld_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output logic                    addr_src_o,
    output logic                    rst_src_o,
    output logic                    rg_wr_o,
    output logic                    alu_ld_o,
    output logic                    mdr_ld_o,
    output ctrl_pkg::pc_src_t       pc_src_o,
    output ctrl_pkg::a_src_t        a_src_o,
    output ctrl_pkg::b_src_t        b_src_o,
    output ctrl_pkg::wd_src_t       wd_src_o,
    output ctrl_pkg::alu_op_t       alu_op_o
);

    // ----------------------------------------------------------------------
    // Sequencer interconnect
    // ----------------------------------------------------------------------
    logic              vec_pc_ld;
    ctrl_pkg::pc_src_t vec_pc_src;
    logic              vec_mem_rd;
    logic              vec_done;

    logic              exec_start;
    logic              exec_is_store;
    logic              exec_last;

    logic              ex_alu_ld;
    logic              ex_addr_src;
    logic              ex_mem_rd;
    logic              ex_mem_wr;
    logic              ex_mdr_ld;
    logic              ex_rg_wr;
    ctrl_pkg::a_src_t  ex_a_src;
    ctrl_pkg::b_src_t  ex_b_src;
    ctrl_pkg::wd_src_t ex_wd_src;

    vector_seq u_vector (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .vec_pc_ld_o   (vec_pc_ld),
        .vec_pc_src_o  (vec_pc_src),
        .vec_mem_rd_o  (vec_mem_rd),
        .vec_done_o    (vec_done)
    );

    // Owns every top-level output
    phase_seq #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_phase (
        .clk_i           (clk_i),
        .resetComplete   (resetComplete),
        .ir_i            (ir_i),
        .mem_busy_i      (mem_busy_i),
        .vec_pc_ld_i     (vec_pc_ld),
        .vec_pc_src_i    (vec_pc_src),
        .vec_mem_rd_i    (vec_mem_rd),
        .vec_done_i      (vec_done),
        .ex_alu_ld_i     (ex_alu_ld),
        .ex_a_src_i      (ex_a_src),
        .ex_b_src_i      (ex_b_src),
        .ex_addr_src_i   (ex_addr_src),
        .ex_mem_rd_i     (ex_mem_rd),
        .ex_mem_wr_i     (ex_mem_wr),
        .ex_mdr_ld_i     (ex_mdr_ld),
        .ex_rg_wr_i      (ex_rg_wr),
        .ex_wd_src_i     (ex_wd_src),
        .exec_last_i     (exec_last),
        .exec_start_o    (exec_start),
        .exec_is_store_o (exec_is_store),
        .ready_o         (ready_o),
        .ir_ld_o         (ir_ld_o),
        .pc_ld_o         (pc_ld_o),
        .mem_rd_o        (mem_rd_o),
        .mem_wr_o        (mem_wr_o),
        .addr_src_o      (addr_src_o),
        .rst_src_o       (rst_src_o),
        .rg_wr_o         (rg_wr_o),
        .alu_ld_o        (alu_ld_o),
        .mdr_ld_o        (mdr_ld_o),
        .pc_src_o        (pc_src_o),
        .a_src_o         (a_src_o),
        .b_src_o         (b_src_o),
        .wd_src_o        (wd_src_o),
        .alu_op_o        (alu_op_o)
    );

    mem_exec_seq u_exec (
        .clk_i           (clk_i),
        .resetComplete   (resetComplete),
        .exec_start_i    (exec_start),
        .exec_is_store_i (exec_is_store),
        .ex_alu_ld_o     (ex_alu_ld),
        .ex_addr_src_o   (ex_addr_src),
        .ex_mem_rd_o     (ex_mem_rd),
        .ex_mem_wr_o     (ex_mem_wr),
        .ex_mdr_ld_o     (ex_mdr_ld),
        .ex_rg_wr_o      (ex_rg_wr),
        .ex_a_src_o      (ex_a_src),
        .ex_b_src_o      (ex_b_src),
        .ex_wd_src_o     (ex_wd_src),
        .exec_last_o     (exec_last)
    );

endmodule

`default_nettype wire

// File: hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // ----------------------------------------------------------------------
    // Sequencer state encodings
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        vec0,               // Load PC from vector constant
        vec1,               // Read vector location
        vec2,               // Load PC from memory
        vec3,               // Read first instruction
        vec4                // First instruction on memory output
    } vector_state_t;

    typedef enum logic [1:0] {
        ph_reset,
        ph_fetch,
        ph_decode,
        ph_execute
    } phase_t;

    typedef enum logic [2:0] {
        ld_addr,            // Load address into ALUOut
        ld_mem_acc,         // Memory read at computed address
        ld_mdr,             // Capture read data in MDR
        ld_wb,              // MDR to register file
        st_addr,            // Store address into ALUOut
        st_mem_acc,         // Read for byte merge
        st_write,           // Merged write
        ex_idle
    } exec_state_t;

    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_other            // R-type and anything unknown
    } op_class_t;

    // ----------------------------------------------------------------------
    // Datapath select codes
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        pc_alu    = 2'd0,   // ALU result direct
        pc_vector = 2'd2,   // Reset vector constant
        pc_mem    = 2'd3    // Reset address read from memory
    } pc_src_t;

    typedef enum logic [1:0] {
        a_pc  = 2'd0,
        a_rs1 = 2'd2
    } a_src_t;

    typedef enum logic [1:0] {
        b_four = 2'd1,      // Constant +4 for PC advance
        b_imm  = 2'd2
    } b_src_t;

    typedef enum logic [1:0] {
        wd_alu = 2'd0,
        wd_mdr = 2'd2
    } wd_src_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0
    } alu_op_t;

    // RV32I opcode field
    localparam int OPCODE_BITS = 7;
    localparam logic [OPCODE_BITS-1:0] OPC_LOAD  = 7'b0000011;
    localparam logic [OPCODE_BITS-1:0] OPC_STORE = 7'b0100011;

endpackage

`default_nettype wire

// File: hdl/mem_exec_seq.sv
`default_nettype none

module mem_exec_seq (
    input  wire                 clk_i,
    input  wire                 resetComplete,
    input  wire                 exec_start_i,       // Decode of a load or store
    input  wire                 exec_is_store_i,
    output logic                ex_alu_ld_o,
    output logic                ex_addr_src_o,
    output logic                ex_mem_rd_o,
    output logic                ex_mem_wr_o,
    output logic                ex_mdr_ld_o,
    output logic                ex_rg_wr_o,
    output ctrl_pkg::a_src_t    ex_a_src_o,
    output ctrl_pkg::b_src_t    ex_b_src_o,
    output ctrl_pkg::wd_src_t   ex_wd_src_o,
    output logic                exec_last_o         // Final substate
);

    ctrl_pkg::exec_state_t state_q;
    ctrl_pkg::exec_state_t state_d;

    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            state_q <= ctrl_pkg::ex_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------------------
    // Substate chain and strobes
    // ----------------------------------------------------------------------
    always_comb begin
        state_d       = state_q;
        ex_alu_ld_o   = 1'b0;
        ex_addr_src_o = 1'b0;                       // PC addresses memory
        ex_mem_rd_o   = 1'b0;
        ex_mem_wr_o   = 1'b0;
        ex_mdr_ld_o   = 1'b0;
        ex_rg_wr_o    = 1'b0;
        ex_a_src_o    = ctrl_pkg::a_pc;
        ex_b_src_o    = ctrl_pkg::b_four;
        ex_wd_src_o   = ctrl_pkg::wd_alu;
        exec_last_o   = 1'b0;

        case (state_q)
            ctrl_pkg::ex_idle: begin
                if (exec_start_i) begin
                    state_d = exec_is_store_i ? ctrl_pkg::st_addr : ctrl_pkg::ld_addr;
                end
            end

            // Load path
            ctrl_pkg::ld_addr: begin
                ex_alu_ld_o = 1'b1;                 // rs1 + imm into ALUOut
                ex_a_src_o  = ctrl_pkg::a_rs1;
                ex_b_src_o  = ctrl_pkg::b_imm;
                state_d     = ctrl_pkg::ld_mem_acc;
            end
            ctrl_pkg::ld_mem_acc: begin
                ex_mem_rd_o   = 1'b1;
                ex_addr_src_o = 1'b1;               // ALUOut as address
                state_d       = ctrl_pkg::ld_mdr;
            end
            ctrl_pkg::ld_mdr: begin
                ex_mem_rd_o   = 1'b1;
                ex_addr_src_o = 1'b1;
                ex_mdr_ld_o   = 1'b1;               // Data valid on memory out
                state_d       = ctrl_pkg::ld_wb;
            end
            ctrl_pkg::ld_wb: begin
                ex_rg_wr_o  = 1'b1;
                ex_wd_src_o = ctrl_pkg::wd_mdr;
                ex_mem_rd_o = 1'b1;                 // Start read of next instruction
                exec_last_o = 1'b1;
                state_d     = ctrl_pkg::ex_idle;
            end

            // Store path
            ctrl_pkg::st_addr: begin
                ex_alu_ld_o   = 1'b1;
                ex_a_src_o    = ctrl_pkg::a_rs1;
                ex_b_src_o    = ctrl_pkg::b_imm;
                ex_addr_src_o = 1'b1;
                state_d       = ctrl_pkg::st_mem_acc;
            end
            ctrl_pkg::st_mem_acc: begin
                ex_mem_rd_o   = 1'b1;               // Old word for sub-word merge
                ex_addr_src_o = 1'b1;
                state_d       = ctrl_pkg::st_write;
            end
            ctrl_pkg::st_write: begin
                ex_mem_wr_o   = 1'b1;
                ex_addr_src_o = 1'b1;
                exec_last_o   = 1'b1;
                state_d       = ctrl_pkg::ex_idle;
            end

            default: state_d = ctrl_pkg::ex_idle;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/phase_seq.sv
`default_nettype none

module phase_seq #(
    parameter int DATA_WIDTH = 32
) (
    input  wire                     clk_i,
    input  wire                     resetComplete,
    input  wire  [DATA_WIDTH-1:0]   ir_i,
    input  wire                     mem_busy_i,         // Only looked at in Fetch
    // Reset-vector strobes
    input  wire                     vec_pc_ld_i,
    input  wire ctrl_pkg::pc_src_t  vec_pc_src_i,
    input  wire                     vec_mem_rd_i,
    input  wire                     vec_done_i,
    // Execute strobes
    input  wire                     ex_alu_ld_i,
    input  wire ctrl_pkg::a_src_t   ex_a_src_i,
    input  wire ctrl_pkg::b_src_t   ex_b_src_i,
    input  wire                     ex_addr_src_i,
    input  wire                     ex_mem_rd_i,
    input  wire                     ex_mem_wr_i,
    input  wire                     ex_mdr_ld_i,
    input  wire                     ex_rg_wr_i,
    input  wire ctrl_pkg::wd_src_t  ex_wd_src_i,
    input  wire                     exec_last_i,
    output logic                    exec_start_o,
    output logic                    exec_is_store_o,
    // Datapath controls
    output logic                    ready_o,
    output logic                    ir_ld_o,
    output logic                    pc_ld_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output logic                    addr_src_o,
    output logic                    rst_src_o,
    output logic                    rg_wr_o,
    output logic                    alu_ld_o,
    output logic                    mdr_ld_o,
    output ctrl_pkg::pc_src_t       pc_src_o,
    output ctrl_pkg::a_src_t        a_src_o,
    output ctrl_pkg::b_src_t        b_src_o,
    output ctrl_pkg::wd_src_t       wd_src_o,
    output ctrl_pkg::alu_op_t       alu_op_o
);

    ctrl_pkg::phase_t    phase_q;
    ctrl_pkg::phase_t    phase_d;
    ctrl_pkg::op_class_t op_class;
    logic [ctrl_pkg::OPCODE_BITS-1:0] opcode;
    logic ready_q;                                      // Vector sequence finished

    assign opcode = ir_i[ctrl_pkg::OPCODE_BITS-1:0];

    // Opcode class for Decode
    always_comb begin
        case (opcode)
            ctrl_pkg::OPC_LOAD:  op_class = ctrl_pkg::op_load;
            ctrl_pkg::OPC_STORE: op_class = ctrl_pkg::op_store;
            default:             op_class = ctrl_pkg::op_other;
        endcase
    end

    assign exec_is_store_o = (op_class == ctrl_pkg::op_store);
    assign ready_o         = ready_q | vec_done_i;      // High from vec4 on

    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            phase_q <= ctrl_pkg::ph_reset;
            ready_q <= 1'b0;
        end else begin
            phase_q <= phase_d;
            if (vec_done_i) begin
                ready_q <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Phase sequencing and output merge
    // ----------------------------------------------------------------------
    always_comb begin
        phase_d      = phase_q;
        exec_start_o = 1'b0;
        ir_ld_o      = 1'b0;
        pc_ld_o      = 1'b0;
        mem_rd_o     = 1'b0;
        mem_wr_o     = 1'b0;
        addr_src_o   = 1'b0;
        rst_src_o    = 1'b0;
        rg_wr_o      = 1'b0;
        alu_ld_o     = 1'b0;
        mdr_ld_o     = 1'b0;
        pc_src_o     = ctrl_pkg::pc_alu;
        a_src_o      = ctrl_pkg::a_pc;
        b_src_o      = ctrl_pkg::b_four;
        wd_src_o     = ctrl_pkg::wd_alu;
        alu_op_o     = ctrl_pkg::alu_add;               // Only op this sequencer needs

        case (phase_q)
            ctrl_pkg::ph_reset: begin
                pc_ld_o   = vec_pc_ld_i;
                pc_src_o  = vec_pc_src_i;
                mem_rd_o  = vec_mem_rd_i;
                rst_src_o = vec_pc_ld_i | vec_mem_rd_i; // Vector steps 0 to 3
                if (vec_done_i) begin
                    phase_d = ctrl_pkg::ph_fetch;
                end
            end
            ctrl_pkg::ph_fetch: begin
                if (!mem_busy_i) begin
                    ir_ld_o = 1'b1;                     // Instruction on memory out
                    phase_d = ctrl_pkg::ph_decode;
                end
            end
            ctrl_pkg::ph_decode: begin
                alu_ld_o = 1'b1;                        // PC + 4
                pc_ld_o  = 1'b1;
                if (op_class == ctrl_pkg::op_other) begin
                    phase_d = ctrl_pkg::ph_fetch;       // Nothing to execute
                end else begin
                    exec_start_o = 1'b1;
                    phase_d      = ctrl_pkg::ph_execute;
                end
            end
            ctrl_pkg::ph_execute: begin
                alu_ld_o   = ex_alu_ld_i;
                a_src_o    = ex_a_src_i;
                b_src_o    = ex_b_src_i;
                addr_src_o = ex_addr_src_i;
                mem_rd_o   = ex_mem_rd_i;
                mem_wr_o   = ex_mem_wr_i;
                mdr_ld_o   = ex_mdr_ld_i;
                rg_wr_o    = ex_rg_wr_i;
                wd_src_o   = ex_wd_src_i;
                if (exec_last_i) begin
                    phase_d = ctrl_pkg::ph_fetch;
                end
            end
            default: phase_d = ctrl_pkg::ph_reset;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/vector_seq.sv
`default_nettype none

module vector_seq (
    input  wire                 clk_i,
    input  wire                 resetComplete,
    output logic                vec_pc_ld_o,    // PC load request
    output ctrl_pkg::pc_src_t   vec_pc_src_o,
    output logic                vec_mem_rd_o,
    output logic                vec_done_o      // One pulse on first vec4 cycle
);

    ctrl_pkg::vector_state_t step_q;
    logic run_q;                                // Set on first edge out of reset
    logic done_q;                               // vec4 already reported

    // ----------------------------------------------------------------------
    // Step counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            step_q <= ctrl_pkg::vec0;
            run_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (run_q) begin
                case (step_q)
                    ctrl_pkg::vec0: step_q <= ctrl_pkg::vec1;
                    ctrl_pkg::vec1: step_q <= ctrl_pkg::vec2;
                    ctrl_pkg::vec2: step_q <= ctrl_pkg::vec3;
                    ctrl_pkg::vec3: step_q <= ctrl_pkg::vec4;
                    ctrl_pkg::vec4: begin
                        step_q <= ctrl_pkg::vec4;   // Parked until next reset
                        done_q <= 1'b1;
                    end
                    default: step_q <= ctrl_pkg::vec0;
                endcase
            end
        end
    end

    // Step decode
    always_comb begin
        vec_pc_ld_o  = 1'b0;
        vec_pc_src_o = ctrl_pkg::pc_alu;
        vec_mem_rd_o = 1'b0;
        vec_done_o   = 1'b0;
        if (run_q) begin
            case (step_q)
                ctrl_pkg::vec0: begin
                    vec_pc_ld_o  = 1'b1;
                    vec_pc_src_o = ctrl_pkg::pc_vector;
                end
                ctrl_pkg::vec1: vec_mem_rd_o = 1'b1;    // Fetch reset address
                ctrl_pkg::vec2: begin
                    vec_pc_ld_o  = 1'b1;
                    vec_pc_src_o = ctrl_pkg::pc_mem;
                end
                ctrl_pkg::vec3: vec_mem_rd_o = 1'b1;    // Fetch first instruction
                ctrl_pkg::vec4: vec_done_o = ~done_q;
                default: vec_pc_ld_o = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the control matrix testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module control_matrix_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vcontrol_matrix_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: verif/control_matrix_tb.sv
`default_nettype none

module control_matrix_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int N_INSTR         = 12;
    localparam int MID_INSTR       = 5;         // Load cut short by reset
    localparam int WATCHDOG_CYCLES = N_INSTR * 12 + 40;

    // RV32I major opcodes
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_JAL   = 7'b1101111;

    // Datapath select codes
    localparam logic [1:0] PC_ALU    = 2'd0;
    localparam logic [1:0] PC_VECTOR = 2'd2;
    localparam logic [1:0] PC_MEM    = 2'd3;
    localparam logic [1:0] A_PC      = 2'd0;
    localparam logic [1:0] A_RS1     = 2'd2;
    localparam logic [1:0] B_FOUR    = 2'd1;
    localparam logic [1:0] B_IMM     = 2'd2;
    localparam logic [1:0] WD_ALU    = 2'd0;
    localparam logic [1:0] WD_MDR    = 2'd2;
    localparam logic [3:0] ALU_ADD   = 4'd0;

    localparam logic [1:0] C_LOAD  = 2'd0;
    localparam logic [1:0] C_STORE = 2'd1;
    localparam logic [1:0] C_OTHER = 2'd2;      // R-type and unknown

    localparam int T_VEC   = 0;
    localparam int T_FETCH = 1;
    localparam int T_LOAD  = 2;
    localparam int T_STORE = 3;
    localparam int T_OTHER = 4;
    localparam int T_MID   = 5;
    localparam int N_TESTS = 6;

    typedef enum logic [2:0] {M_INIT, M_PRE, M_VEC, M_FETCH, M_DECODE, M_EXEC} model_state_t;

    // All DUT outputs as one packed word
    typedef struct packed {
        logic       ready;
        logic       ir_ld;
        logic       pc_ld;
        logic       mem_rd;
        logic       mem_wr;
        logic       addr_src;
        logic       rst_src;
        logic       rg_wr;
        logic       alu_ld;
        logic       mdr_ld;
        logic [1:0] pc_src;
        logic [1:0] a_src;
        logic [1:0] b_src;
        logic [1:0] wd_src;
        logic [3:0] alu_op;
    } ctrl_vec_t;

    logic        clk_i;
    logic        resetComplete = 1'b1;
    logic        mem_busy_i    = 1'b0;
    logic [31:0] ir_i          = '0;
    logic        ready_o;
    logic        ir_ld_o;
    logic        pc_ld_o;
    logic        mem_rd_o;
    logic        mem_wr_o;
    logic        addr_src_o;
    logic        rst_src_o;
    logic        rg_wr_o;
    logic        alu_ld_o;
    logic        mdr_ld_o;
    logic [1:0]  pc_src_o;
    logic [1:0]  a_src_o;
    logic [1:0]  b_src_o;
    logic [1:0]  wd_src_o;
    logic [3:0]  alu_op_o;

    ctrl_vec_t    act_vec;
    ctrl_vec_t    exp_vec;
    model_state_t m_state = M_INIT;             // Expected DUT phase
    logic [2:0]   m_step  = 3'd0;
    logic [1:0]   cls;
    logic [2:0]   last_step;
    logic         mid_seen = 1'b0;
    int           hits [N_TESTS];
    int           errs [N_TESTS];
    int           extra_errs [N_TESTS];
    int           n_ir_ld = 0;
    int           n_fetched = 0;
    int           n_failed = 0;
    int           n_errs = 0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk_o(clk_i));

    control_matrix #(.DATA_WIDTH(32)) dut0 (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ir_i          (ir_i),
        .mem_busy_i    (mem_busy_i),
        .ready_o       (ready_o),
        .ir_ld_o       (ir_ld_o),
        .pc_ld_o       (pc_ld_o),
        .mem_rd_o      (mem_rd_o),
        .mem_wr_o      (mem_wr_o),
        .addr_src_o    (addr_src_o),
        .rst_src_o     (rst_src_o),
        .rg_wr_o       (rg_wr_o),
        .alu_ld_o      (alu_ld_o),
        .mdr_ld_o      (mdr_ld_o),
        .pc_src_o      (pc_src_o),
        .a_src_o       (a_src_o),
        .b_src_o       (b_src_o),
        .wd_src_o      (wd_src_o),
        .alu_op_o      (alu_op_o)
    );

    assign act_vec = {ready_o, ir_ld_o, pc_ld_o, mem_rd_o, mem_wr_o, addr_src_o, rst_src_o,
                      rg_wr_o, alu_ld_o, mdr_ld_o, pc_src_o, a_src_o, b_src_o, wd_src_o,
                      alu_op_o};

    function automatic logic [6:0] opcode_at(input int idx);
        case (idx)
            1, 4, 7, 10: return OP_STORE;
            2, 6:        return OP_REG;
            8:           return OP_JAL;         // Unknown to this sequencer
            default:     return OP_LOAD;        // 0, 3, 5, 9, 11
        endcase
    endfunction

    function automatic logic [1:0] classify(input logic [6:0] op);
        if (op == OP_LOAD) return C_LOAD;
        if (op == OP_STORE) return C_STORE;
        return C_OTHER;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            T_VEC:   return "reset_vector";
            T_FETCH: return "fetch_wait";
            T_LOAD:  return "load_seq";
            T_STORE: return "store_seq";
            T_OTHER: return "other_opcode";
            default: return "mid_reset";
        endcase
    endfunction

    assign cls       = classify(ir_i[6:0]);     // ir_i held until next Fetch
    assign last_step = (cls == C_STORE) ? 3'd2 : 3'd3;

    // ----------------------------------------------------------------------
    // Reference phase model and check coverage
    // ----------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (m_state == M_PRE || m_state == M_VEC) hits[mid_seen ? T_MID : T_VEC]++;
        if (m_state == M_FETCH) hits[T_FETCH]++;
        if (m_state == M_DECODE || m_state == M_EXEC) begin
            if (cls == C_LOAD) hits[T_LOAD]++;
            if (cls == C_STORE) hits[T_STORE]++;
        end
        if (m_state == M_DECODE && cls == C_OTHER) hits[T_OTHER]++;
        if (m_state != M_INIT && ir_ld_o) n_ir_ld++;

        if (resetComplete) begin
            m_state <= M_PRE;
        end else begin
            case (m_state)
                M_PRE: begin
                    m_state <= M_VEC;           // Cycle 0 follows
                    m_step  <= 3'd0;
                end
                M_VEC: begin
                    if (m_step == 3'd4) m_state <= M_FETCH;
                    else m_step <= m_step + 3'd1;
                end
                M_FETCH: begin
                    if (!mem_busy_i) begin
                        m_state <= M_DECODE;
                        n_fetched++;
                    end
                end
                M_DECODE: begin
                    m_step  <= 3'd0;
                    m_state <= (cls == C_OTHER) ? M_FETCH : M_EXEC;
                end
                M_EXEC: begin
                    if (m_step == last_step) m_state <= M_FETCH;
                    else m_step <= m_step + 3'd1;
                end
                default: m_state <= M_INIT;     // Waits for first reset edge
            endcase
        end
    end

    // Expected strobes per model cycle
    always_comb begin
        exp_vec        = '0;
        exp_vec.pc_src = PC_ALU;
        exp_vec.a_src  = A_PC;
        exp_vec.b_src  = B_FOUR;
        exp_vec.wd_src = WD_ALU;
        exp_vec.alu_op = ALU_ADD;
        exp_vec.ready  = (m_state == M_FETCH || m_state == M_DECODE || m_state == M_EXEC);
        case (m_state)
            M_VEC: begin
                exp_vec.rst_src = (m_step != 3'd4);
                exp_vec.ready   = (m_step == 3'd4);
                case (m_step)
                    3'd0: {exp_vec.pc_ld, exp_vec.pc_src} = {1'b1, PC_VECTOR};
                    3'd2: {exp_vec.pc_ld, exp_vec.pc_src} = {1'b1, PC_MEM};
                    3'd1, 3'd3: exp_vec.mem_rd = 1'b1;
                    default: exp_vec.mem_rd = 1'b0;
                endcase
            end
            M_FETCH: exp_vec.ir_ld = !mem_busy_i;
            M_DECODE: begin
                exp_vec.alu_ld = 1'b1;          // PC + 4
                exp_vec.pc_ld  = 1'b1;
            end
            M_EXEC: begin
                if (m_step == 3'd0) begin
                    exp_vec.alu_ld   = 1'b1;
                    exp_vec.a_src    = A_RS1;
                    exp_vec.b_src    = B_IMM;
                    exp_vec.addr_src = (cls == C_STORE);
                end else if (cls == C_STORE) begin
                    exp_vec.addr_src = 1'b1;
                    exp_vec.mem_rd   = (m_step == 3'd1);
                    exp_vec.mem_wr   = (m_step == 3'd2);
                end else begin
                    exp_vec.mem_rd   = 1'b1;    // Steps 1 to 3 of a load
                    exp_vec.addr_src = (m_step != 3'd3);
                    exp_vec.mdr_ld   = (m_step == 3'd2);
                    exp_vec.rg_wr    = (m_step == 3'd3);
                    exp_vec.wd_src   = (m_step == 3'd3) ? WD_MDR : WD_ALU;
                end
            end
            default: exp_vec.ready = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Memory model driving on the falling edge
    // ----------------------------------------------------------------------
    int          seed = 371;
    int          busy_left = 0;
    int          next_instr = 0;
    logic        fetch_armed = 1'b0;
    logic        drained = 1'b0;                // Program exhausted
    logic [31:0] rnd;

    always @(negedge clk_i) begin
        if (m_state == M_FETCH) begin
            if (!fetch_armed) begin
                fetch_armed = 1'b1;
                if (next_instr < N_INSTR) begin
                    rnd        = $random(seed);
                    ir_i       = {rnd[31:7], opcode_at(next_instr)};
                    next_instr = next_instr + 1;
                    busy_left  = $random(seed) & 3;     // 0 to 3 wait cycles
                end else begin
                    drained = 1'b1;
                end
            end
            mem_busy_i = drained || (busy_left > 0);    // Fetch parked once drained
            if (busy_left > 0) busy_left = busy_left - 1;
        end else begin
            fetch_armed = 1'b0;
            rnd         = $random(seed);
            mem_busy_i  = rnd[0];                       // Don't care outside Fetch
        end
    end

    task automatic report_mismatch(input int t, input logic [21:0] e, input logic [21:0] a);
        errs[t]++;
        $display("FAIL %s: expected %h, actual %h at %0t", test_name(t), e, a, $time);
    endtask

    task automatic report_event(input int t, input string msg);
        errs[t]++;
        $display("ERROR %s: %s at %0t", test_name(t), msg, $time);
    endtask

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    vector_chk: assert property (@(posedge clk_i)
        (m_state == M_PRE || m_state == M_VEC) |-> (act_vec == exp_vec))
        else report_mismatch($sampled(mid_seen) ? T_MID : T_VEC, $sampled(exp_vec),
                             $sampled(act_vec));
    fetch_chk: assert property (@(posedge clk_i) (m_state == M_FETCH) |-> (act_vec == exp_vec))
        else report_mismatch(T_FETCH, $sampled(exp_vec), $sampled(act_vec));
    busy_chk: assert property (@(posedge clk_i)
        (m_state != M_INIT) |-> !(ir_ld_o && mem_busy_i))
        else report_event(T_FETCH, "ir_ld_o high while mem_busy_i is high");
    load_chk: assert property (@(posedge clk_i)
        ((m_state == M_DECODE || m_state == M_EXEC) && cls == C_LOAD) |-> (act_vec == exp_vec))
        else report_mismatch(T_LOAD, $sampled(exp_vec), $sampled(act_vec));
    store_chk: assert property (@(posedge clk_i)
        ((m_state == M_DECODE || m_state == M_EXEC) && cls == C_STORE) |-> (act_vec == exp_vec))
        else report_mismatch(T_STORE, $sampled(exp_vec), $sampled(act_vec));
    store_wr_chk: assert property (@(posedge clk_i)
        (m_state != M_INIT && mem_wr_o) |->
            (m_state == M_EXEC && cls == C_STORE && m_step == 3'd2))
        else report_event(T_STORE, "mem_wr_o high outside the third store cycle");
    other_chk: assert property (@(posedge clk_i)
        (m_state == M_DECODE && cls == C_OTHER) |-> (act_vec == exp_vec))
        else report_mismatch(T_OTHER, $sampled(exp_vec), $sampled(act_vec));

    task automatic finish_test(input int t);
        if (hits[t] == 0) begin
            extra_errs[t]++;
            $display("ERROR %s: stimulus never reached its checks", test_name(t));
        end
        if (errs[t] + extra_errs[t] != 0) n_failed++;
        n_errs = n_errs + errs[t] + extra_errs[t];
        $display("test %s: %s, %0d checked cycles, %0d errors", test_name(t),
                 (errs[t] + extra_errs[t] == 0) ? "ok" : "failed", hits[t],
                 errs[t] + extra_errs[t]);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        resetComplete = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_i);
        resetComplete = 1'b0;
        while (m_state != M_FETCH) @(negedge clk_i);
        finish_test(T_VEC);

        // Reset in the middle of a load
        while (!(m_state == M_EXEC && m_step == 3'd1 && next_instr == MID_INSTR + 1)) begin
            @(negedge clk_i);
        end
        mid_seen      = 1'b1;
        resetComplete = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_i);
        resetComplete = 1'b0;

        while (!drained) @(negedge clk_i);
        repeat (2) @(negedge clk_i);
        ir_count_chk: assert (n_ir_ld == n_fetched)
            else begin
                extra_errs[T_FETCH]++;
                $display("FAIL fetch_wait: expected %0d ir_ld_o pulses, actual %0d",
                         n_fetched, n_ir_ld);
            end
        finish_test(T_FETCH);
        finish_test(T_LOAD);
        finish_test(T_STORE);
        finish_test(T_OTHER);
        finish_test(T_MID);
        $display("summary: %0d tests, %0d failed, %0d errors", N_TESTS, n_failed, n_errs);
        if (n_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR watchdog: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8                    // Time units per cycle
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;                           // First rising edge at PERIOD/2
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/ctrl_pkg.sv
hdl/vector_seq.sv
hdl/mem_exec_seq.sv
hdl/phase_seq.sv
hdl/control_matrix.sv
verif/tb_clock_gen.sv
verif/control_matrix_tb.sv
